//--- verilog/dot_engine_macros.svh
/*
 * Dot-product engine build constants
 * Operand and accumulator widths, pipeline depths and the lane and
 * chunk counts shared by every block of the engine
 */

`ifndef DOT_ENGINE_MACROS_SVH
`define DOT_ENGINE_MACROS_SVH

// Width of one signed activation or weight element
`define DATA_WIDTH 8

// Register stages behind each multiplier and behind each adder level
`define MULT_LATENCY 4
`define TREE_DELAY 1

// Engine geometry
`define NUM_LANES 4
`define MAX_CHUNKS 4
`define ACC_WIDTH 24
`define CHUNK_IDX_WIDTH 2
`define LANE_IDX_WIDTH 2

// Feeder register, multiplier chain, dot2 adder and dot4 adder
`define PIPE_LATENCY (1 + `MULT_LATENCY + 2 * `TREE_DELAY)

`endif

//--- verilog/dot_engine_pkg.sv
/*
 * Dot-product engine types
 * Packed bundles for operand vectors, per-lane operand pairs, beat
 * control and the accumulated lane sums
 */

`include "dot_engine_macros.svh"

package dot_engine_pkg;

   // -------------------------------------------------------------------------
   // Operand vectors
   // -------------------------------------------------------------------------

   // Four signed elements, e0 in the low byte so a row reads naturally in hex
   typedef struct packed {
      logic signed [`DATA_WIDTH-1:0] e3;
      logic signed [`DATA_WIDTH-1:0] e2;
      logic signed [`DATA_WIDTH-1:0] e1;
      logic signed [`DATA_WIDTH-1:0] e0;
   } operand_vec_t;

   // What one dot4 lane needs for a beat: the shared activation and its own weights
   typedef struct packed {
      operand_vec_t act;
      operand_vec_t wt;
   } lane_operands_t;

   // -------------------------------------------------------------------------
   // Control and results
   // -------------------------------------------------------------------------

   // Group markers ride along with the valid bit through the whole pipe
   typedef struct packed {
      logic valid;
      logic first;
      logic last;
   } beat_ctrl_t;

   typedef logic signed [`ACC_WIDTH-1:0] lane_sum_t;

endpackage

//--- verilog/nbit_mlength_shift_register.sv
/*
 * Enabled delay line
 * A chain of DEPTH registers of WIDTH bits that moves only while ena
 * is high, with a synchronous clear. DEPTH of zero passes d straight
 * through
 */

`timescale 1ns/1ps

module nbit_mlength_shift_register #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 1
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             ena,
   input  logic [WIDTH-1:0] d,
   output logic [WIDTH-1:0] q
);

   generate
      if (DEPTH == 0) begin : g_pass
         // No stages at all, the delay line collapses to a wire
         assign q = d;
      end else begin : g_chain
         logic [WIDTH-1:0] stage [DEPTH];

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               for (int i = 0; i < DEPTH; i++) begin
                  stage[i] <= '0;
               end
            end else if (ena) begin
               // Every stage advances together, a stall freezes the whole chain
               stage[0] <= d;
               for (int i = 1; i < DEPTH; i++) begin
                  stage[i] <= stage[i-1];
               end
            end
         end

         // Oldest entry is the output
         assign q = stage[DEPTH-1];
      end
   endgenerate

endmodule

//--- verilog/dot2_alm.sv
/*
 * Signed dot2
 * Two signed products, each pipelined through MULT_LATENCY stages, then
 * a sign-extended add held for TREE_DELAY stages
 */

`timescale 1ns/1ps
`include "dot_engine_macros.svh"

module dot2_alm (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            ena,
   input  logic signed [`DATA_WIDTH-1:0]   a1,
   input  logic signed [`DATA_WIDTH-1:0]   a2,
   input  logic signed [`DATA_WIDTH-1:0]   b1,
   input  logic signed [`DATA_WIDTH-1:0]   b2,
   output logic signed [2*`DATA_WIDTH:0]   res
);

   // Full product width, -128 * -128 still fits as a positive value
   localparam int PROD_W = 2 * `DATA_WIDTH;

   logic signed [PROD_W-1:0] prod1;
   logic signed [PROD_W-1:0] prod2;
   logic signed [PROD_W-1:0] prod1_q;
   logic signed [PROD_W-1:0] prod2_q;
   logic signed [PROD_W:0]   sum;

   // -------------------------------------------------------------------------
   // Multipliers
   // -------------------------------------------------------------------------

   // Both operands are signed, so the products come out sign correct
   assign prod1 = a1 * b1;
   assign prod2 = a2 * b2;

   // The registers behind each product stand for the multiplier pipeline
   nbit_mlength_shift_register #(.WIDTH(PROD_W), .DEPTH(`MULT_LATENCY)) mult1_pipe_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .d     (prod1),
      .q     (prod1_q)
   );

   nbit_mlength_shift_register #(.WIDTH(PROD_W), .DEPTH(`MULT_LATENCY)) mult2_pipe_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .d     (prod2),
      .q     (prod2_q)
   );

   // -------------------------------------------------------------------------
   // Adder
   // -------------------------------------------------------------------------

   // One extra bit keeps the sum of two full-range products exact
   assign sum = prod1_q + prod2_q;

   nbit_mlength_shift_register #(.WIDTH(PROD_W + 1), .DEPTH(`TREE_DELAY)) sum_pipe_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .d     (sum),
      .q     (res)
   );

endmodule

//--- verilog/dot4_alm.sv
/*
 * Signed dot4 lane
 * Splits the operand bundle over two dot2 halves and adds their
 * sign-extended results behind one more TREE_DELAY stage
 */

`timescale 1ns/1ps
`include "dot_engine_macros.svh"

module dot4_alm
   import dot_engine_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            ena,
   input  lane_operands_t                  ops,
   output logic signed [2*`DATA_WIDTH+1:0] res
);

   logic signed [2*`DATA_WIDTH:0]   dot2_res [2];
   logic signed [2*`DATA_WIDTH+1:0] dot2_res_e [2];
   logic signed [2*`DATA_WIDTH+1:0] sum;

   // Low half works on elements 0 and 1
   dot2_alm dot2_lo_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .a1    (ops.act.e0),
      .a2    (ops.act.e1),
      .b1    (ops.wt.e0),
      .b2    (ops.wt.e1),
      .res   (dot2_res[0])
   );

   // High half works on elements 2 and 3
   dot2_alm dot2_hi_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .a1    (ops.act.e2),
      .a2    (ops.act.e3),
      .b1    (ops.wt.e2),
      .b2    (ops.wt.e3),
      .res   (dot2_res[1])
   );

   // Widen by one bit before the add so four full products never overflow
   assign dot2_res_e[0] = dot2_res[0];
   assign dot2_res_e[1] = dot2_res[1];
   assign sum           = dot2_res_e[0] + dot2_res_e[1];

   nbit_mlength_shift_register #(.WIDTH(2*`DATA_WIDTH + 2), .DEPTH(`TREE_DELAY)) dot4_pipe_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .d     (sum),
      .q     (res)
   );

endmodule

//--- verilog/operand_feeder.sv
/*
 * Operand feeder
 * Holds one weight row per lane and chunk, tracks the chunk position
 * inside a group and registers the operand bundle of every lane
 */

`timescale 1ns/1ps
`include "dot_engine_macros.svh"

module operand_feeder
   import dot_engine_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  ena,
   input  logic                                  wt_we,
   input  logic [`LANE_IDX_WIDTH-1:0]            wt_lane,
   input  logic [`CHUNK_IDX_WIDTH-1:0]           wt_chunk,
   input  operand_vec_t                          wt_row,
   input  beat_ctrl_t                            in_ctrl,
   input  operand_vec_t                          act,
   output lane_operands_t [`NUM_LANES-1:0]       lane_ops,
   output beat_ctrl_t                            ops_ctrl
);

   operand_vec_t                wt_mem [`NUM_LANES][`MAX_CHUNKS];
   logic [`CHUNK_IDX_WIDTH-1:0] chunk_cnt;
   logic [`CHUNK_IDX_WIDTH-1:0] cur_chunk;

   // Weight writes ignore ena, so rows can be loaded while the pipe is stalled
   always_ff @(posedge clk) begin
      if (wt_we) begin
         wt_mem[wt_lane][wt_chunk] <= wt_row;
      end
   end

   // -------------------------------------------------------------------------
   // Chunk position
   // -------------------------------------------------------------------------

   // A first beat always reads row zero, whatever the counter holds
   assign cur_chunk = in_ctrl.first ? '0 : chunk_cnt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         chunk_cnt <= '0;
      end else if (ena && in_ctrl.valid) begin
         chunk_cnt <= in_ctrl.last ? '0 : cur_chunk + 1'b1;
      end
   end

   // -------------------------------------------------------------------------
   // Operand and control registers
   // -------------------------------------------------------------------------

   // Every lane gets the same activation next to its own weight row
   always_ff @(posedge clk) begin
      if (ena && in_ctrl.valid) begin
         for (int l = 0; l < `NUM_LANES; l++) begin
            lane_ops[l].act <= act;
            lane_ops[l].wt  <= wt_mem[l][cur_chunk];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ops_ctrl <= '0;
      end else if (ena) begin
         ops_ctrl <= in_ctrl;
      end
   end

   // The beat that reads the last chunk row must also close the group
   a_group_length : assert property (@(posedge clk) disable iff (!rst_n)
      (ena && in_ctrl.valid && cur_chunk == `MAX_CHUNKS - 1) |-> in_ctrl.last);

endmodule

//--- verilog/result_accumulator.sv
/*
 * Result accumulator
 * Delays the beat control to line up with the lane results, sums each
 * lane over a group and pulses out_valid with the finished sums
 */

`timescale 1ns/1ps
`include "dot_engine_macros.svh"

module result_accumulator
   import dot_engine_pkg::*;
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      ena,
   input  beat_ctrl_t                                ops_ctrl,
   input  logic [`NUM_LANES-1:0][2*`DATA_WIDTH+1:0]  lane_res,
   output logic                                      out_valid,
   output lane_sum_t [`NUM_LANES-1:0]                out_sums
);

   beat_ctrl_t res_ctrl;

   // -------------------------------------------------------------------------
   // Control alignment
   // -------------------------------------------------------------------------

   // The feeder register is already behind ops_ctrl, so one stage less
   nbit_mlength_shift_register #(
      .WIDTH ($bits(beat_ctrl_t)),
      .DEPTH (`PIPE_LATENCY - 1)
   ) ctrl_delay_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ena   (ena),
      .d     (ops_ctrl),
      .q     (res_ctrl)
   );

   // -------------------------------------------------------------------------
   // Per-lane sums
   // -------------------------------------------------------------------------

   for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
      lane_sum_t res_ext;
      lane_sum_t acc;
      lane_sum_t next_sum;
      lane_sum_t sum_q;

      assign res_ext  = lane_sum_t'($signed(lane_res[l]));
      // First beat of a group starts fresh, any other beat adds on
      assign next_sum = res_ctrl.first ? res_ext : acc + res_ext;

      always_ff @(posedge clk) begin
         if (ena && res_ctrl.valid) begin
            acc <= next_sum;
            if (res_ctrl.last) begin
               sum_q <= next_sum;
            end
         end
      end

      assign out_sums[l] = sum_q;
   end

   // Strobe is forced low on stalled cycles so one group gives one pulse
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= ena && res_ctrl.valid && res_ctrl.last;
      end
   end

   // Group markers that reach this point must belong to a real beat
   a_ctrl_markers : assert property (@(posedge clk) disable iff (!rst_n)
      (ena && !res_ctrl.valid) |-> !(res_ctrl.first || res_ctrl.last));

endmodule

//--- verilog/dot_engine_top.sv
/*
 * Dot-product engine top level
 * Feeder, NUM_LANES signed dot4 lanes sharing one activation beat, and
 * the group accumulator that reports every lane's sum
 */

`timescale 1ns/1ps
`include "dot_engine_macros.svh"

module dot_engine_top
   import dot_engine_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            ena,
   input  logic                            wt_we,
   input  logic [`LANE_IDX_WIDTH-1:0]      wt_lane,
   input  logic [`CHUNK_IDX_WIDTH-1:0]     wt_chunk,
   input  operand_vec_t                    wt_row,
   input  beat_ctrl_t                      in_ctrl,
   input  operand_vec_t                    act,
   output logic                            out_valid,
   output lane_sum_t [`NUM_LANES-1:0]      out_sums
);

   lane_operands_t [`NUM_LANES-1:0]             lane_ops;
   beat_ctrl_t                                  ops_ctrl;
   logic [`NUM_LANES-1:0][2*`DATA_WIDTH+1:0]    lane_res;

   operand_feeder operand_feeder_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .ena      (ena),
      .wt_we    (wt_we),
      .wt_lane  (wt_lane),
      .wt_chunk (wt_chunk),
      .wt_row   (wt_row),
      .in_ctrl  (in_ctrl),
      .act      (act),
      .lane_ops (lane_ops),
      .ops_ctrl (ops_ctrl)
   );

   // One dot4 per lane, all fed in the same cycle
   for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
      dot4_alm dot4_alm_inst (
         .clk   (clk),
         .rst_n (rst_n),
         .ena   (ena),
         .ops   (lane_ops[l]),
         .res   (lane_res[l])
      );
   end

   result_accumulator result_accumulator_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .ena       (ena),
      .ops_ctrl  (ops_ctrl),
      .lane_res  (lane_res),
      .out_valid (out_valid),
      .out_sums  (out_sums)
   );

endmodule

//--- tb/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * Free-running clock of PERIOD ns and an active-low reset held for
 * RESET_CYCLES rising edges, released on a falling edge
 */

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Release away from the rising edge so the DUT sees a clean reset level
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

//--- tb/dot_engine_tb.sv
/*
 * Dot-product engine testbench
 * Applies a table of groups (directed and random) with weight loads and
 * stalls, predicts every lane sum from the activations and weight rows,
 * and matches each out_valid pulse against the oldest open group
 */

`timescale 1ns/1ps
`include "dot_engine_macros.svh"

module dot_engine_tb
   import dot_engine_pkg::*;
();

   localparam int NUM_TESTS = 12;

   logic                          clk;
   logic                          rst_n;
   logic                          ena;
   logic                          wt_we;
   logic [`LANE_IDX_WIDTH-1:0]    wt_lane;
   logic [`CHUNK_IDX_WIDTH-1:0]   wt_chunk;
   operand_vec_t                  wt_row;
   beat_ctrl_t                    in_ctrl;
   operand_vec_t                  act;
   logic                          out_valid;
   lane_sum_t [`NUM_LANES-1:0]    out_sums;

   // Stimulus table, one group per row, expected sums filled in while building
   string        t_name  [NUM_TESTS];
   int           t_chunks[NUM_TESTS];
   bit           t_load  [NUM_TESTS];
   int           t_stall [NUM_TESTS][`MAX_CHUNKS];
   operand_vec_t t_act   [NUM_TESTS][`MAX_CHUNKS];
   operand_vec_t t_wt    [NUM_TESTS][`NUM_LANES][`MAX_CHUNKS];
   longint       t_exp   [NUM_TESTS][`NUM_LANES];
   int           t_last_edge[NUM_TESTS];
   int           test_errs[NUM_TESTS];

   int  pending[$];
   int  edge_cnt = 0;
   logic ena_at_edge = 1'b0;
   int  seen = 0;
   int  errors = 0;
   int  checks = 0;
   int  total_beats = 0;
   bit  table_ready = 1'b0;

   tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(5)) clock_gen_inst (
      .clk   (clk),
      .rst_n (rst_n)
   );

   dot_engine_top dot_engine_top_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .ena       (ena),
      .wt_we     (wt_we),
      .wt_lane   (wt_lane),
      .wt_chunk  (wt_chunk),
      .wt_row    (wt_row),
      .in_ctrl   (in_ctrl),
      .act       (act),
      .out_valid (out_valid),
      .out_sums  (out_sums)
   );

   // --------------------------------------------------------------------------
   // Checking helpers
   // --------------------------------------------------------------------------

   task automatic check(input int idx, input string what, input longint expected,
                        input longint actual);
      string name;
      name = (idx >= 0) ? t_name[idx] : "reset";
      checks++;
      if (expected !== actual) begin
         errors++;
         if (idx >= 0) test_errs[idx]++;
         $display("error: %s %s: expected %0d, actual %0d", name, what, expected, actual);
      end
   endtask

   // Signed dot product of one activation beat with one weight row
   function automatic longint dot_product(input operand_vec_t a, input operand_vec_t w);
      return longint'($signed(a.e0)) * longint'($signed(w.e0))
           + longint'($signed(a.e1)) * longint'($signed(w.e1))
           + longint'($signed(a.e2)) * longint'($signed(w.e2))
           + longint'($signed(a.e3)) * longint'($signed(w.e3));
   endfunction

   // --------------------------------------------------------------------------
   // Table construction
   // --------------------------------------------------------------------------

   task automatic build_table();
      operand_vec_t wt_model [`NUM_LANES][`MAX_CHUNKS];
      longint       sum;
      // Random background for every row, directed rows overwrite parts of it
      for (int r = 0; r < NUM_TESTS; r++) begin
         t_name[r]   = $sformatf("rand_%0d", r);
         t_chunks[r] = 1 + ($urandom % `MAX_CHUNKS);
         t_load[r]   = $urandom % 2;
         for (int k = 0; k < `MAX_CHUNKS; k++) begin
            t_act[r][k]   = $urandom;
            t_stall[r][k] = ($urandom % 4 == 0) ? ($urandom % 4) : 0;
            for (int l = 0; l < `NUM_LANES; l++) t_wt[r][l][k] = $urandom;
         end
      end
      for (int r = 0; r < 8; r++) begin
         t_stall[r] = '{default: 0};
      end
      t_name[0]   = "single_pos";
      t_chunks[0] = 1;
      t_load[0]   = 1;
      t_act[0][0] = 32'h04030201;
      for (int l = 0; l < `NUM_LANES; l++) begin
         t_wt[0][l][0] = {8'(4*l + 4), 8'(4*l + 3), 8'(4*l + 2), 8'(4*l + 1)};
         t_wt[1][l][0].e0 = 8'(3 - 2*l);
         t_wt[1][l][0].e1 = 8'(-9 * (l + 1));
         t_wt[1][l][0].e2 = 8'(l - 2);
         t_wt[1][l][0].e3 = 8'(l - 127);
         t_wt[2][l][0] = 32'h80808080;
      end
      // Elements are -5, 7, -128 and 127 from e0 upwards
      t_name[1]   = "single_mixed";
      t_chunks[1] = 1;
      t_load[1]   = 1;
      t_act[1][0] = 32'h7f8007fb;
      t_name[2]   = "single_min";
      t_chunks[2] = 1;
      t_load[2]   = 1;
      t_act[2][0] = 32'h80808080;
      t_name[3]   = "multi2_reload";
      t_chunks[3] = 2;
      t_load[3]   = 1;
      t_name[4]   = "multi4_b2b";
      t_chunks[4] = 4;
      t_load[4]   = 0;
      t_name[5]   = "multi3_b2b";
      t_chunks[5] = 3;
      t_load[5]   = 0;
      t_name[6]   = "stall_mid";
      t_chunks[6] = 4;
      t_load[6]   = 0;
      t_stall[6]  = '{0, 2, 3, 1};
      t_name[7]   = "reload_after";
      t_chunks[7] = 2;
      t_load[7]   = 1;

      // Expected sums follow the weights that are loaded when each group runs
      for (int r = 0; r < NUM_TESTS; r++) begin
         if (t_load[r]) wt_model = t_wt[r];
         for (int l = 0; l < `NUM_LANES; l++) begin
            sum = 0;
            for (int k = 0; k < t_chunks[r]; k++) begin
               sum += dot_product(t_act[r][k], wt_model[l][k]);
            end
            t_exp[r][l] = sum;
         end
         total_beats += t_chunks[r];
      end
   endtask

   // --------------------------------------------------------------------------
   // Drivers, all changes on the falling edge
   // --------------------------------------------------------------------------

   // Every lane and chunk row is rewritten, the pipe keeps draining meanwhile
   task automatic load_weights(input int idx);
      for (int l = 0; l < `NUM_LANES; l++) begin
         for (int c = 0; c < `MAX_CHUNKS; c++) begin
            @(negedge clk);
            ena      = 1'b1;
            in_ctrl  = '0;
            wt_we    = 1'b1;
            wt_lane  = l[`LANE_IDX_WIDTH-1:0];
            wt_chunk = c[`CHUNK_IDX_WIDTH-1:0];
            wt_row   = t_wt[idx][l][c];
         end
      end
   endtask

   task automatic send_group(input int idx);
      for (int k = 0; k < t_chunks[idx]; k++) begin
         // A stalled cycle offers a junk beat that must not be taken
         repeat (t_stall[idx][k]) begin
            @(negedge clk);
            ena           = 1'b0;
            wt_we         = 1'b0;
            in_ctrl       = '0;
            in_ctrl.valid = 1'b1;
            act           = $urandom;
         end
         @(negedge clk);
         ena           = 1'b1;
         wt_we         = 1'b0;
         in_ctrl.valid = 1'b1;
         in_ctrl.first = (k == 0);
         in_ctrl.last  = (k == t_chunks[idx] - 1);
         act           = t_act[idx][k];
         if (in_ctrl.last) begin
            t_last_edge[idx] = edge_cnt + 1;
            // Queue on the rising edge so the falling-edge monitor never races it
            @(posedge clk);
            pending.push_back(idx);
         end
      end
   endtask

   // --------------------------------------------------------------------------
   // Monitor
   // --------------------------------------------------------------------------

   always @(posedge clk) begin
      ena_at_edge <= ena;
      if (ena) edge_cnt <= edge_cnt + 1;
   end

   always @(negedge clk) begin : monitor
      int idx;
      if (rst_n && out_valid) begin
         if (!ena_at_edge) begin
            errors++;
            $display("out_valid rose on an edge where ena was low");
         end
         if (pending.size() == 0) begin
            errors++;
            $display("out_valid pulsed with no group outstanding");
         end else begin
            idx = pending.pop_front();
            for (int l = 0; l < `NUM_LANES; l++) begin
               check(idx, $sformatf("lane %0d", l), t_exp[idx][l], out_sums[l]);
            end
            // Result lands PIPE_LATENCY enabled edges after the last beat was taken
            check(idx, "latency", `PIPE_LATENCY, edge_cnt - t_last_edge[idx]);
            $display("test %s: %s", t_name[idx], (test_errs[idx] == 0) ? "pass" : "fail");
            seen++;
         end
      end
   end

   // --------------------------------------------------------------------------
   // Main sequence and watchdog
   // --------------------------------------------------------------------------

   initial begin : main
      int seed_val;
      int passed;
      ena      = 1'b0;
      wt_we    = 1'b0;
      wt_lane  = '0;
      wt_chunk = '0;
      wt_row   = '0;
      in_ctrl  = '0;
      act      = '0;
      seed_val = $urandom(32'h7e9f3f24);
      build_table();
      table_ready = 1'b1;

      while (rst_n !== 1'b1) begin
         @(negedge clk);
         check(-1, "out_valid", 0, out_valid);
      end

      for (int r = 0; r < NUM_TESTS; r++) begin
         if (t_load[r]) load_weights(r);
         send_group(r);
      end
      @(negedge clk);
      ena     = 1'b1;
      wt_we   = 1'b0;
      in_ctrl = '0;

      wait (seen == NUM_TESTS);
      // Idle tail catches any extra pulse after the last group
      repeat (20) @(negedge clk);

      passed = 0;
      for (int r = 0; r < NUM_TESTS; r++) begin
         if (test_errs[r] == 0) passed++;
      end
      $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
               NUM_TESTS, passed, NUM_TESTS - passed, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin : watchdog
      int limit;
      wait (table_ready);
      limit = 20 * total_beats + 200;
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles, %0d of %0d results seen",
               limit, seen, NUM_TESTS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+verilog
verilog/dot_engine_pkg.sv
verilog/nbit_mlength_shift_register.sv
verilog/dot2_alm.sv
verilog/dot4_alm.sv
verilog/operand_feeder.sv
verilog/result_accumulator.sv
verilog/dot_engine_top.sv
tb/tb_clock_gen.sv
tb/dot_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the dot-product engine testbench with Verilator and run it.
# Exit status is zero only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   -f vlog.f \
   --top-module dot_engine_tb \
   -Mdir obj_dir -o dot_engine_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/dot_engine_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q -F '*** PASSED ***'; then
   exit 0
fi
exit 1
